// File: tb.f
design/uart_rx_pkg.sv
design/rx_frame_sampler.sv
design/rx_fifo_store.sv
design/rx_ready_ctrl.sv
design/uart_rx_top.sv
tests/tb_clock_gen.sv
tests/tb_uart_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the run from its log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_rx \
  -f tb.f -o tb_uart_rx_sim \
  && ./obj_dir/tb_uart_rx_sim > "$LOG" 2>&1
cat "$LOG" 2>/dev/null
grep -q "Simulation completed successfully" "$LOG" 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: tests/tb_uart_rx.sv
module tb_uart_rx;
  timeunit 1ns;
  timeprecision 100ps;

  // One baud tick every 4 clocks and 16 ticks per bit, so a bit lasts 64 clocks
  localparam int TICK_DIV = 4;
  localparam int BIT_CLKS = 16 * TICK_DIV;
  localparam int FRAME_TIMEOUT = 2000;
  localparam int FLAG_TIMEOUT = 50;
  localparam int NUM_ROWS = 15;
  localparam logic [1:0] INJ_NONE = 2'd0;
  localparam logic [1:0] INJ_PARITY = 2'd1;
  localparam logic [1:0] INJ_STOP = 2'd2;
  localparam int SEL_DONE = 0;
  localparam int SEL_READY = 1;
  localparam int SEL_EMPTY = 2;

  // One frame per row, then a number of reads that pop the oldest expected entries
  typedef struct packed {
    logic [7:0]                 data;
    uart_rx_pkg::data_width_e   width;
    uart_rx_pkg::parity_mode_e  parity;
    uart_rx_pkg::stop_bits_e    stop;
    logic [1:0]                 inject;
    logic                       stream;
    logic [5:0]                 threshold;
    logic [2:0]                 reads;
    logic                       exp_ready;
    logic [7:0]                 exp_data;
    logic                       exp_par;
    logic                       exp_frm;
    logic                       exp_ovr;
  } row_t;

  logic clk;
  logic rst_n;
  logic enable;
  logic baud_tick;
  logic rx;
  logic fifo_read;
  logic stream_mode;
  logic [5:0] threshold;
  uart_rx_pkg::data_width_e data_width;
  uart_rx_pkg::stop_bits_e stop_bits;
  uart_rx_pkg::parity_mode_e parity_mode;
  logic [7:0] rx_data;
  logic parity_error;
  logic frame_error;
  logic overrun_error;
  logic rx_done;
  logic rx_ready;
  logic fifo_empty;
  logic fifo_full;

  row_t rows [NUM_ROWS];
  // Expected entries in buffer order, packed as overrun, frame, parity and data
  logic [10:0] exp_q [$];
  int done_count = 0;
  int full_count = 0;
  int frames_sent = 0;

  tb_clock_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  uart_rx_top DUT (
    .clk_i(clk), .rst_n_i(rst_n), .enable_i(enable), .baud_tick_i(baud_tick),
    .rx_i(rx), .fifo_read_i(fifo_read), .stream_mode_i(stream_mode),
    .threshold_i(threshold), .data_width_i(data_width), .stop_bits_i(stop_bits),
    .parity_mode_i(parity_mode), .rx_data_o(rx_data), .parity_error_o(parity_error),
    .frame_error_o(frame_error), .overrun_error_o(overrun_error), .rx_done_o(rx_done),
    .rx_ready_o(rx_ready), .fifo_empty_o(fifo_empty), .fifo_full_o(fifo_full)
  );

  // --------------------
  // Tick source and monitors
  // --------------------

  initial begin
    int div;
    div = 0;
    baud_tick = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      baud_tick = (div == TICK_DIV - 1);
      div = (div == TICK_DIV - 1) ? 0 : div + 1;
    end
  end

  // Outputs are counted at the falling edge where they are settled
  always @(negedge clk) begin
    if (rst_n && rx_done) done_count = done_count + 1;
    if (rst_n && fifo_full) full_count = full_count + 1;
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  // Polls one output at each falling edge until it shows the value or time runs out
  task automatic wait_output(input int sel, input logic value, input int limit,
                             input string what);
    int cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < limit) begin
      @(negedge clk);
      case (sel)
        SEL_DONE:  seen = (rx_done === value);
        SEL_READY: seen = (rx_ready === value);
        default:   seen = (fifo_empty === value);
      endcase
      cycles++;
    end
    if (!seen) abort_run($sformatf("Timed out after %0d cycles waiting for %s", limit, what));
  endtask

  task automatic apply_config(input uart_rx_pkg::data_width_e width,
                              input uart_rx_pkg::parity_mode_e parity,
                              input uart_rx_pkg::stop_bits_e stop,
                              input logic stream, input logic [5:0] thr);
    @(posedge clk);
    #1;
    data_width = width;
    parity_mode = parity;
    stop_bits = stop;
    stream_mode = stream;
    threshold = thr;
  endtask

  task automatic hold_bit(input logic value);
    rx = value;
    repeat (BIT_CLKS) @(posedge clk);
    #1;
  endtask

  // Start bit, data LSB first, optional parity, then the stop bits
  task automatic send_frame(input logic [7:0] data, input uart_rx_pkg::data_width_e width,
                            input uart_rx_pkg::parity_mode_e parity,
                            input uart_rx_pkg::stop_bits_e stop, input logic [1:0] inject);
    int nbits;
    int i;
    logic par;
    nbits = 5 + int'(width);
    par = 1'b0;
    @(posedge clk);
    #1;
    hold_bit(1'b0);
    for (i = 0; i < nbits; i++) begin
      hold_bit(data[i]);
      par = par ^ data[i];
    end
    if (parity != uart_rx_pkg::PAR_NONE) begin
      // Even parity makes the count of ones even, odd parity makes it odd
      if (parity == uart_rx_pkg::PAR_ODD) par = ~par;
      if (inject == INJ_PARITY) par = ~par;
      hold_bit(par);
    end
    // A stop error always lands on the first stop bit
    hold_bit(inject != INJ_STOP);
    if (stop == uart_rx_pkg::SB_2BIT) hold_bit(1'b1);
  endtask

  task automatic run_frame(input logic [7:0] data, input uart_rx_pkg::data_width_e width,
                           input uart_rx_pkg::parity_mode_e parity,
                           input uart_rx_pkg::stop_bits_e stop, input logic [1:0] inject);
    fork
      send_frame(data, width, parity, stop, inject);
      wait_output(SEL_DONE, 1'b1, FRAME_TIMEOUT, "rx_done_o");
    join
    frames_sent++;
    @(negedge clk);
    check_value("rx_done_o pulse count", done_count, frames_sent);
  endtask

  // Flags must stay low until the read, then match the popped entry
  task automatic read_entry();
    logic [10:0] exp;
    @(negedge clk);
    if (exp_q.size() == 0) abort_run("A read was requested with no entry left to expect");
    exp = exp_q.pop_front();
    check_value("fifo_empty_o before read", fifo_empty, 0);
    check_value("error flags without read", {overrun_error, frame_error, parity_error}, 0);
    @(posedge clk);
    #1;
    fifo_read = 1'b1;
    #2;
    check_value("rx_data_o", rx_data, exp[7:0]);
    check_value("parity_error_o", parity_error, exp[8]);
    check_value("frame_error_o", frame_error, exp[9]);
    check_value("overrun_error_o", overrun_error, exp[10]);
    @(posedge clk);
    #1;
    fifo_read = 1'b0;
  endtask

  task automatic drain_buffer();
    while (exp_q.size() > 0) read_entry();
    wait_output(SEL_EMPTY, 1'b1, FLAG_TIMEOUT, "fifo_empty_o high");
    wait_output(SEL_READY, 1'b0, FLAG_TIMEOUT, "rx_ready_o low");
  endtask

  // Random 8N1 frames into an empty buffer, frames beyond its depth are dropped
  task automatic fill_buffer(input logic stream, input logic [5:0] thr, input int nframes,
                             input int exp_pulses);
    logic [7:0] data;
    logic ready_model;
    int base;
    int k;
    apply_config(uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 stream, thr);
    ready_model = 1'b0;
    base = full_count;
    for (k = 0; k < nframes; k++) begin
      data = 8'($urandom);
      if (exp_q.size() < uart_rx_pkg::FIFO_DEPTH) exp_q.push_back({ready_model, 2'b00, data});
      run_frame(data, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                INJ_NONE);
      if (!stream) ready_model = 1'b1;
      else if (thr == 0) ready_model = ready_model | (exp_q.size() == uart_rx_pkg::FIFO_DEPTH);
      else ready_model = ready_model | (exp_q.size() >= thr);
      check_value("rx_ready_o after fill frame", rx_ready, ready_model);
    end
    check_value("fifo_full_o pulse count", full_count - base, exp_pulses);
    drain_buffer();
  endtask

  // --------------------
  // Stimulus table
  // --------------------

  function automatic void load_rows();
    // Standard mode 8N1, one read each
    rows[0]  = '{8'hA5, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 INJ_NONE, 1'b0, 6'd0, 3'd1, 1'b1, 8'hA5, 1'b0, 1'b0, 1'b0};
    rows[1]  = '{8'h3C, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 INJ_NONE, 1'b0, 6'd0, 3'd1, 1'b1, 8'h3C, 1'b0, 1'b0, 1'b0};
    // Short characters with parity, upper bits set on the sent byte must not arrive
    rows[2]  = '{8'hF6, uart_rx_pkg::DW_5BIT, uart_rx_pkg::PAR_EVEN, uart_rx_pkg::SB_2BIT,
                 INJ_NONE, 1'b0, 6'd0, 3'd1, 1'b1, 8'h16, 1'b0, 1'b0, 1'b0};
    rows[3]  = '{8'hAB, uart_rx_pkg::DW_6BIT, uart_rx_pkg::PAR_ODD, uart_rx_pkg::SB_2BIT,
                 INJ_NONE, 1'b0, 6'd0, 3'd1, 1'b1, 8'h2B, 1'b0, 1'b0, 1'b0};
    rows[4]  = '{8'hC5, uart_rx_pkg::DW_7BIT, uart_rx_pkg::PAR_EVEN, uart_rx_pkg::SB_2BIT,
                 INJ_NONE, 1'b0, 6'd0, 3'd1, 1'b1, 8'h45, 1'b0, 1'b0, 1'b0};
    rows[5]  = '{8'h9A, uart_rx_pkg::DW_7BIT, uart_rx_pkg::PAR_ODD, uart_rx_pkg::SB_2BIT,
                 INJ_NONE, 1'b0, 6'd0, 3'd1, 1'b1, 8'h1A, 1'b0, 1'b0, 1'b0};
    // Injected parity and stop errors
    rows[6]  = '{8'h5E, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_EVEN, uart_rx_pkg::SB_1BIT,
                 INJ_PARITY, 1'b0, 6'd0, 3'd1, 1'b1, 8'h5E, 1'b1, 1'b0, 1'b0};
    rows[7]  = '{8'h21, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_2BIT,
                 INJ_STOP, 1'b0, 6'd0, 3'd1, 1'b1, 8'h21, 1'b0, 1'b1, 1'b0};
    rows[8]  = '{8'h0D, uart_rx_pkg::DW_6BIT, uart_rx_pkg::PAR_ODD, uart_rx_pkg::SB_2BIT,
                 INJ_PARITY, 1'b0, 6'd0, 3'd1, 1'b1, 8'h0D, 1'b1, 1'b0, 1'b0};
    // Second frame arrives while ready is still set
    rows[9]  = '{8'h11, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 INJ_NONE, 1'b0, 6'd0, 3'd0, 1'b1, 8'h11, 1'b0, 1'b0, 1'b0};
    rows[10] = '{8'h22, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 INJ_NONE, 1'b0, 6'd0, 3'd2, 1'b1, 8'h22, 1'b0, 1'b0, 1'b1};
    // Stream mode, ready only once four entries wait
    rows[11] = '{8'h41, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 INJ_NONE, 1'b1, 6'd4, 3'd0, 1'b0, 8'h41, 1'b0, 1'b0, 1'b0};
    rows[12] = '{8'h42, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 INJ_NONE, 1'b1, 6'd4, 3'd0, 1'b0, 8'h42, 1'b0, 1'b0, 1'b0};
    rows[13] = '{8'h43, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 INJ_NONE, 1'b1, 6'd4, 3'd0, 1'b0, 8'h43, 1'b0, 1'b0, 1'b0};
    rows[14] = '{8'h44, uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT,
                 INJ_NONE, 1'b1, 6'd4, 3'd4, 1'b1, 8'h44, 1'b0, 1'b0, 1'b0};
  endfunction

  initial begin
    row_t row;
    int r;
    int i;
    int cycles;
    int unsigned seed;
    seed = $urandom(39963);
    enable = 1'b1;
    rx = 1'b1;
    fifo_read = 1'b0;
    stream_mode = 1'b0;
    threshold = '0;
    data_width = uart_rx_pkg::DW_8BIT;
    stop_bits = uart_rx_pkg::SB_1BIT;
    parity_mode = uart_rx_pkg::PAR_NONE;
    load_rows();

    // Reset may still be unknown at time zero, so only a clean high counts as released
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) abort_run("Reset was never released");
    @(negedge clk);
    check_value("outputs after reset",
                {rx_done, rx_ready, fifo_full, parity_error, frame_error, overrun_error}, 0);
    check_value("fifo_empty_o after reset", fifo_empty, 1);

    for (r = 0; r < NUM_ROWS; r++) begin
      row = rows[r];
      apply_config(row.width, row.parity, row.stop, row.stream, row.threshold);
      exp_q.push_back({row.exp_ovr, row.exp_frm, row.exp_par, row.exp_data});
      run_frame(row.data, row.width, row.parity, row.stop, row.inject);
      check_value("rx_ready_o after frame", rx_ready, row.exp_ready);
      check_value("fifo_empty_o after frame", fifo_empty, 0);
      for (i = 0; i < int'(row.reads); i++) begin
        // In stream mode ready holds until the buffer runs empty
        if (row.stream) begin
          @(negedge clk);
          check_value("rx_ready_o before stream read", rx_ready, 1);
        end
        read_entry();
      end
      if (row.reads != 0 && exp_q.size() == 0) begin
        wait_output(SEL_EMPTY, 1'b1, FLAG_TIMEOUT, "fifo_empty_o high");
        wait_output(SEL_READY, 1'b0, FLAG_TIMEOUT, "rx_ready_o low");
      end
    end

    // Buffer depth plus one drops the last frame, full pulses once
    fill_buffer(1'b0, 6'd0, uart_rx_pkg::FIFO_DEPTH + 1, 1);
    // A zero threshold reports the full buffer through ready alone
    fill_buffer(1'b1, 6'd0, uart_rx_pkg::FIFO_DEPTH, 0);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule : tb_uart_rx

// File: tests/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset is released 1 ns after a rising edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule : tb_clock_gen

// File: design/uart_rx_top.sv
module uart_rx_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              enable_i,
  input  logic                              baud_tick_i,
  input  logic                              rx_i,
  input  logic                              fifo_read_i,
  input  logic                              stream_mode_i,
  input  logic [uart_rx_pkg::LEVEL_W-1:0]   threshold_i,
  input  uart_rx_pkg::data_width_e          data_width_i,
  input  uart_rx_pkg::stop_bits_e           stop_bits_i,
  input  uart_rx_pkg::parity_mode_e         parity_mode_i,
  output logic [uart_rx_pkg::DATA_W-1:0]    rx_data_o,
  output logic                              parity_error_o,
  output logic                              frame_error_o,
  output logic                              overrun_error_o,
  output logic                              rx_done_o,
  output logic                              rx_ready_o,
  output logic                              fifo_empty_o,
  output logic                              fifo_full_o
);

  logic                             wr_en;
  logic [uart_rx_pkg::ENTRY_W-1:0]  wr_entry;
  logic [uart_rx_pkg::ENTRY_W-1:0]  head;
  logic [uart_rx_pkg::LEVEL_W-1:0]  level;
  logic                             frame_done;
  logic                             ready;
  logic                             empty;
  logic                             full;

  // The sampler and the buffer sit side by side, ready logic watches both
  rx_frame_sampler u_sampler (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .enable_i(enable_i),
    .baud_tick_i(baud_tick_i), .rx_i(rx_i),
    .data_width_i(data_width_i), .stop_bits_i(stop_bits_i),
    .parity_mode_i(parity_mode_i), .full_i(full), .ready_i(ready),
    .wr_en_o(wr_en), .wr_entry_o(wr_entry), .frame_done_o(frame_done)
  );

  rx_fifo_store u_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .wr_en_i(wr_en),
    .wr_entry_i(wr_entry), .rd_en_i(fifo_read_i), .head_o(head),
    .level_o(level), .empty_o(empty), .full_o(full)
  );

  rx_ready_ctrl u_ready (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .frame_done_i(frame_done),
    .rd_en_i(fifo_read_i), .stream_mode_i(stream_mode_i),
    .threshold_i(threshold_i), .level_i(level), .empty_i(empty),
    .full_i(full), .ready_o(ready), .full_pulse_o(fifo_full_o)
  );

  // --------------------
  // Head split
  // --------------------

  assign rx_data_o = head[uart_rx_pkg::DATA_W-1:0];

  // Flags show only on the read that pops their entry
  assign parity_error_o = head[uart_rx_pkg::PARITY_ERR_IDX] & fifo_read_i;
  assign frame_error_o = head[uart_rx_pkg::FRAME_ERR_IDX] & fifo_read_i;
  assign overrun_error_o = head[uart_rx_pkg::OVERRUN_IDX] & fifo_read_i;

  assign rx_done_o = frame_done;
  assign rx_ready_o = ready;
  assign fifo_empty_o = empty;

endmodule : uart_rx_top

// File: design/rx_ready_ctrl.sv
module rx_ready_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              frame_done_i,
  input  logic                              rd_en_i,
  input  logic                              stream_mode_i,
  input  logic [uart_rx_pkg::LEVEL_W-1:0]   threshold_i,
  input  logic [uart_rx_pkg::LEVEL_W-1:0]   level_i,
  input  logic                              empty_i,
  input  logic                              full_i,
  output logic                              ready_o,
  output logic                              full_pulse_o
);

  // --------------------
  // Ready interrupt
  // --------------------

  logic                             ready_q;
  logic                             full_q;
  logic                             full_pulse_q;
  logic                             wr_inc;
  logic                             rd_dec;
  logic                             stream_hit;
  logic                             full_mask;
  logic [uart_rx_pkg::LEVEL_W-1:0]  level_after;

  // The frame is written unless the buffer is full
  assign wr_inc = frame_done_i & ~full_i;
  assign rd_dec = rd_en_i & ~empty_i;

  // Level as it will be once this clock's write and read are done
  assign level_after = level_i + uart_rx_pkg::LEVEL_W'(wr_inc) -
                       uart_rx_pkg::LEVEL_W'(rd_dec);

  // A zero threshold means interrupt only on a full buffer
  assign stream_hit = (threshold_i == '0) ?
                      (level_after == uart_rx_pkg::LEVEL_W'(uart_rx_pkg::FIFO_DEPTH)) :
                      (level_after >= threshold_i);

  // The sampler reads ready back to flag overrun, so a new frame wins over a clear
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else if (stream_mode_i) begin
      if (frame_done_i && stream_hit) begin
        ready_q <= 1'b1;
      end else if (empty_i) begin
        ready_q <= 1'b0;
      end
    end else begin
      if (frame_done_i) begin
        ready_q <= 1'b1;
      end else if (rd_en_i) begin
        ready_q <= 1'b0;
      end
    end
  end

  // --------------------
  // Full edge pulse
  // --------------------

  // In stream mode with a zero threshold ready already reports the full buffer
  assign full_mask = stream_mode_i & (threshold_i == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      full_pulse_q <= 1'b0;
    end else begin
      full_q <= full_i;
      full_pulse_q <= full_i & ~full_q & ~full_mask;
    end
  end

  assign ready_o = ready_q;
  assign full_pulse_o = full_pulse_q;

  // In standard mode only a read may drop ready
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ready_o && !stream_mode_i && !rd_en_i) |=> ready_o);

endmodule : rx_ready_ctrl

// File: design/rx_fifo_store.sv
module rx_fifo_store (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              wr_en_i,
  input  logic [uart_rx_pkg::ENTRY_W-1:0]   wr_entry_i,
  input  logic                              rd_en_i,
  output logic [uart_rx_pkg::ENTRY_W-1:0]   head_o,
  output logic [uart_rx_pkg::LEVEL_W-1:0]   level_o,
  output logic                              empty_o,
  output logic                              full_o
);

  // --------------------
  // Storage and pointers
  // --------------------

  logic [uart_rx_pkg::ENTRY_W-1:0]  mem_q [uart_rx_pkg::FIFO_DEPTH];
  logic [uart_rx_pkg::PTR_W-1:0]    wr_ptr_q;
  logic [uart_rx_pkg::PTR_W-1:0]    rd_ptr_q;
  logic [uart_rx_pkg::LEVEL_W-1:0]  level_q;
  logic [uart_rx_pkg::LEVEL_W-1:0]  level_d;
  logic                             empty_q;
  logic                             full_q;
  logic                             do_wr;
  logic                             do_rd;

  // Writes to a full buffer and reads of an empty one are ignored
  assign do_wr = wr_en_i & ~full_q;
  assign do_rd = rd_en_i & ~empty_q;

  // A simultaneous read and write leaves the level unchanged
  always_comb begin
    case ({do_wr, do_rd})
      2'b10:   level_d = level_q + 1'b1;
      2'b01:   level_d = level_q - 1'b1;
      default: level_d = level_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q <= '0;
      empty_q <= 1'b1;
      full_q <= 1'b0;
    end else begin
      // The depth is a power of two, so the pointers wrap on their own
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      level_q <= level_d;
      // Flags are registered from the next level so they track it exactly
      empty_q <= (level_d == '0);
      full_q <= (level_d == uart_rx_pkg::LEVEL_W'(uart_rx_pkg::FIFO_DEPTH));
    end
  end

  // The head is presented without a read
  assign head_o = mem_q[rd_ptr_q];
  assign level_o = level_q;
  assign empty_o = empty_q;
  assign full_o = full_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    level_q <= uart_rx_pkg::LEVEL_W'(uart_rx_pkg::FIFO_DEPTH));

  // Matching pointers mean an empty buffer unless it has filled up
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    empty_q == ((wr_ptr_q == rd_ptr_q) && !full_q));

endmodule : rx_fifo_store

// File: design/rx_frame_sampler.sv
module rx_frame_sampler (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                enable_i,
  input  logic                                baud_tick_i,
  input  logic                                rx_i,
  input  uart_rx_pkg::data_width_e            data_width_i,
  input  uart_rx_pkg::stop_bits_e             stop_bits_i,
  input  uart_rx_pkg::parity_mode_e           parity_mode_i,
  input  logic                                full_i,
  input  logic                                ready_i,
  output logic                                wr_en_o,
  output logic [uart_rx_pkg::ENTRY_W-1:0]     wr_entry_o,
  output logic                                frame_done_o
);

  // --------------------
  // Sampling control
  // --------------------

  uart_rx_pkg::rx_state_e               state_q;
  logic [uart_rx_pkg::TICK_W-1:0]       tick_cnt_q;
  logic [uart_rx_pkg::BITCNT_W-1:0]     bit_cnt_q;
  logic [uart_rx_pkg::BITCNT_W-1:0]     last_bit_idx;
  logic                                 stop_cnt_q;
  logic                                 ovr_q;
  logic                                 start_edge;
  logic                                 tick_end;
  logic                                 last_stop;

  // Payload of the frame being received
  logic [uart_rx_pkg::DATA_W-1:0]       shift_q;
  logic [uart_rx_pkg::DATA_W-1:0]       data_aligned;
  logic                                 par_bit_q;
  logic                                 stop_ok_q;
  logic                                 data_par;
  logic                                 par_err;

  // A falling line while idle and enabled opens a frame
  assign start_edge = enable_i & ~rx_i;

  // The last tick of a bit period lands in the middle of the next bit
  assign tick_end = baud_tick_i &
                    (tick_cnt_q == uart_rx_pkg::TICK_W'(uart_rx_pkg::OVERSAMPLE - 1));

  // The width code counts up from 5 bits, so the last index is the code plus 4
  assign last_bit_idx = {1'b0, data_width_i} + uart_rx_pkg::BITCNT_W'(4);

  // With two stop bits the first one only arms the counter
  assign last_stop = (stop_bits_i == uart_rx_pkg::SB_1BIT) | stop_cnt_q;

  assign frame_done_o = (state_q == uart_rx_pkg::STOP) & tick_end & last_stop;

  // A full buffer drops the frame
  assign wr_en_o = frame_done_o & ~full_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= uart_rx_pkg::IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q <= '0;
      stop_cnt_q <= 1'b0;
      ovr_q <= 1'b0;
    end else begin
      case (state_q)
        uart_rx_pkg::IDLE: begin
          stop_cnt_q <= 1'b0;
          if (start_edge) begin
            tick_cnt_q <= '0;
            ovr_q <= ready_i;
            state_q <= uart_rx_pkg::START;
          end
        end
        uart_rx_pkg::START: begin
          if (baud_tick_i) begin
            if (tick_cnt_q == uart_rx_pkg::TICK_W'(uart_rx_pkg::MID_TICK)) begin
              tick_cnt_q <= '0;
              bit_cnt_q <= '0;
              // A line back high at mid bit was a glitch
              state_q <= rx_i ? uart_rx_pkg::IDLE : uart_rx_pkg::DATA;
            end else begin
              tick_cnt_q <= tick_cnt_q + 1'b1;
            end
          end
        end
        uart_rx_pkg::DATA: begin
          if (tick_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == last_bit_idx) begin
              state_q <= (parity_mode_i == uart_rx_pkg::PAR_EVEN ||
                          parity_mode_i == uart_rx_pkg::PAR_ODD) ?
                         uart_rx_pkg::PARITY : uart_rx_pkg::STOP;
            end
          end
        end
        uart_rx_pkg::PARITY: begin
          if (tick_end) begin
            state_q <= uart_rx_pkg::STOP;
          end
        end
        uart_rx_pkg::STOP: begin
          if (tick_end) begin
            stop_cnt_q <= 1'b1;
            if (last_stop) begin
              state_q <= uart_rx_pkg::IDLE;
            end
          end
        end
        default: state_q <= uart_rx_pkg::IDLE;
      endcase

      // Bit periods run back to back once the start bit is confirmed
      if (state_q != uart_rx_pkg::IDLE && state_q != uart_rx_pkg::START && baud_tick_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end

      // Ready seen at any point of the frame means the previous entry was still unread
      if (state_q != uart_rx_pkg::IDLE) begin
        ovr_q <= ovr_q | ready_i;
      end
    end
  end

  // Data enters at the top and moves down, so the LSB ends at the bottom
  always_ff @(posedge clk_i) begin
    if (state_q == uart_rx_pkg::IDLE && start_edge) begin
      stop_ok_q <= 1'b1;
    end
    if (state_q == uart_rx_pkg::DATA && tick_end) begin
      shift_q <= {rx_i, shift_q[uart_rx_pkg::DATA_W-1:1]};
    end
    if (state_q == uart_rx_pkg::PARITY && tick_end) begin
      par_bit_q <= rx_i;
    end
    // Any low stop bit is remembered until the frame ends
    if (state_q == uart_rx_pkg::STOP && tick_end) begin
      stop_ok_q <= stop_ok_q & rx_i;
    end
  end

  // --------------------
  // Entry assembly
  // --------------------

  // Short characters sit in the upper bits and are shifted down to bit 0
  always_comb begin
    case (data_width_i)
      uart_rx_pkg::DW_5BIT: data_aligned = {3'b000, shift_q[7:3]};
      uart_rx_pkg::DW_6BIT: data_aligned = {2'b00, shift_q[7:2]};
      uart_rx_pkg::DW_7BIT: data_aligned = {1'b0, shift_q[7:1]};
      default:              data_aligned = shift_q;
    endcase
  end

  // Even parity expects the XOR of the data, odd parity its inverse
  assign data_par = ^data_aligned;

  always_comb begin
    case (parity_mode_i)
      uart_rx_pkg::PAR_EVEN: par_err = (par_bit_q != data_par);
      uart_rx_pkg::PAR_ODD:  par_err = (par_bit_q == data_par);
      default:               par_err = 1'b0;
    endcase
  end

  always_comb begin
    wr_entry_o = '0;
    wr_entry_o[uart_rx_pkg::DATA_W-1:0] = data_aligned;
    wr_entry_o[uart_rx_pkg::PARITY_ERR_IDX] = par_err;
    // The current stop bit is still on the line at the write
    wr_entry_o[uart_rx_pkg::FRAME_ERR_IDX] = ~(stop_ok_q & rx_i);
    wr_entry_o[uart_rx_pkg::OVERRUN_IDX] = ovr_q | ready_i;
  end

  // The stop phase is reached only after every data bit of the width was counted
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    frame_done_o |-> (bit_cnt_q == last_bit_idx + 1'b1));

  // The buffer full flag must block every write
  assert property (@(posedge clk_i) disable iff (!rst_n_i) wr_en_o |-> !full_i);

endmodule : rx_frame_sampler

// File: design/uart_rx_pkg.sv
package uart_rx_pkg;

  // --------------------
  // Widths and entry layout
  // --------------------

  // Width of one received character
  localparam int DATA_W = 8;

  // A buffer entry holds the character and three flag bits above it
  localparam int ENTRY_W = 11;
  localparam int PARITY_ERR_IDX = 8;
  localparam int FRAME_ERR_IDX = 9;
  localparam int OVERRUN_IDX = 10;

  // Number of data bits counted by the sampler, enough for 8 bits
  localparam int BITCNT_W = $clog2(DATA_W);

  // --------------------
  // Buffer sizing
  // --------------------

  localparam int FIFO_DEPTH = 32;
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // The level must hold FIFO_DEPTH itself, so it is one bit wider than the pointers
  localparam int LEVEL_W = 6;

  // --------------------
  // Oversampling
  // --------------------

  // Ticks per bit on the serial line
  localparam int OVERSAMPLE = 16;
  localparam int TICK_W = $clog2(OVERSAMPLE);

  // Tick count at the middle of the start bit
  localparam int MID_TICK = 7;

  // --------------------
  // Mode encodings
  // --------------------

  typedef enum logic [1:0] {DW_5BIT, DW_6BIT, DW_7BIT, DW_8BIT} data_width_e;
  typedef enum logic {SB_1BIT, SB_2BIT} stop_bits_e;
  typedef enum logic [1:0] {PAR_NONE, PAR_EVEN, PAR_ODD} parity_mode_e;
  typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_e;

endpackage : uart_rx_pkg
